// File: Makefile
# Verilator build and run for the IP frame mux

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_ip_arb_mux
FILELIST := ip_arb_mux.f
EXE      := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: design/ip_arb_mux.sv
// arbitrated multiplexer for IP frames
// S_COUNT sources each offer a header and a payload stream, one frame
// at a time is forwarded to the single output

`timescale 1ns/10ps
`default_nettype none

module ip_arb_mux #(
    parameter int S_COUNT    = 4,
    parameter bit ARB_POLICY = ip_mux_pkg::ARB_ROUND_ROBIN
) (
    input  wire                                            clk,
    input  wire                                            rst,
    // source side
    input  wire  [S_COUNT-1:0]                             s_ip_hdr_valid,
    output logic [S_COUNT-1:0]                             s_ip_hdr_ready,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_LEN_W-1:0]   s_ip_length,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_TTL_W-1:0]   s_ip_ttl,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_PROTO_W-1:0] s_ip_protocol,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_ADDR_W-1:0]  s_ip_source_ip,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_ADDR_W-1:0]  s_ip_dest_ip,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::PAYLOAD_W-1:0]  s_payload_tdata,
    input  wire  [S_COUNT-1:0]                             s_payload_tvalid,
    input  wire  [S_COUNT-1:0]                             s_payload_tlast,
    output logic [S_COUNT-1:0]                             s_payload_tready,
    // sink side
    output logic                                           m_ip_hdr_valid,
    input  wire                                            m_ip_hdr_ready,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]                m_ip_length,
    output logic [ip_mux_pkg::IP_TTL_W-1:0]                m_ip_ttl,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0]              m_ip_protocol,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]               m_ip_source_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]               m_ip_dest_ip,
    output logic [ip_mux_pkg::PAYLOAD_W-1:0]               m_payload_tdata,
    output logic                                           m_payload_tvalid,
    output logic                                           m_payload_tlast,
    input  wire                                            m_payload_tready
);

    import ip_mux_pkg::*;

    localparam int IDX_W = $clog2(S_COUNT);

    logic [S_COUNT-1:0]   request;
    logic [S_COUNT-1:0]   acknowledge;
    logic [S_COUNT-1:0]   grant;
    logic                 grant_valid;
    logic [IDX_W-1:0]     grant_index;
    logic                 frame_open;
    logic                 frame_end;
    logic                 skid_ready;
    logic [PAYLOAD_W-1:0] sel_data;
    logic                 sel_valid;
    logic                 sel_last;

    // a granted source cannot request again until its frame ends
    assign request = s_ip_hdr_valid & ~grant;

    // granted payload, only after its header has been captured
    assign sel_data  = s_payload_tdata[grant_index];
    assign sel_last  = s_payload_tlast[grant_index];
    assign sel_valid = s_payload_tvalid[grant_index] && skid_ready &&
                       grant_valid && frame_open;

    // grant is one-hot, so this reaches the granted source only
    assign s_payload_tready = grant & {S_COUNT{skid_ready && frame_open}};

    // last byte of the frame releases the grant
    assign frame_end   = sel_valid && sel_last;
    assign acknowledge = grant & {S_COUNT{frame_end}};

    ip_mux_arbiter #(
        .S_COUNT    (S_COUNT),
        .ARB_POLICY (ARB_POLICY)
    ) i_ip_mux_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    ip_hdr_select #(
        .S_COUNT (S_COUNT)
    ) i_ip_hdr_select (
        .clk            (clk),
        .rst            (rst),
        .grant          (grant),
        .grant_valid    (grant_valid),
        .grant_index    (grant_index),
        .s_ip_length    (s_ip_length),
        .s_ip_ttl       (s_ip_ttl),
        .s_ip_protocol  (s_ip_protocol),
        .s_ip_source_ip (s_ip_source_ip),
        .s_ip_dest_ip   (s_ip_dest_ip),
        .frame_end      (frame_end),
        .m_ip_hdr_ready (m_ip_hdr_ready),
        .s_ip_hdr_ready (s_ip_hdr_ready),
        .frame_open     (frame_open),
        .m_ip_hdr_valid (m_ip_hdr_valid),
        .m_ip_length    (m_ip_length),
        .m_ip_ttl       (m_ip_ttl),
        .m_ip_protocol  (m_ip_protocol),
        .m_ip_source_ip (m_ip_source_ip),
        .m_ip_dest_ip   (m_ip_dest_ip)
    );

    ip_payload_skid i_ip_payload_skid (
        .clk              (clk),
        .rst              (rst),
        .in_data          (sel_data),
        .in_valid         (sel_valid),
        .in_last          (sel_last),
        .in_ready         (skid_ready),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tlast  (m_payload_tlast),
        .m_payload_tready (m_payload_tready)
    );

endmodule

`default_nettype wire

// File: design/ip_hdr_select.sv
// header stage of the IP frame mux
// keeps the frame state and copies the granted header into the output
// registers, then completes the handshake with the granted source

`timescale 1ns/10ps
`default_nettype none

module ip_hdr_select #(
    parameter int S_COUNT = 4
) (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire  [S_COUNT-1:0]                               grant,
    input  wire                                              grant_valid,
    input  wire  [$clog2(S_COUNT)-1:0]                       grant_index,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_LEN_W-1:0]     s_ip_length,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_TTL_W-1:0]     s_ip_ttl,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_PROTO_W-1:0]   s_ip_protocol,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_ADDR_W-1:0]    s_ip_source_ip,
    input  wire  [S_COUNT-1:0][ip_mux_pkg::IP_ADDR_W-1:0]    s_ip_dest_ip,
    input  wire                                              frame_end,
    input  wire                                              m_ip_hdr_ready,
    output logic [S_COUNT-1:0]                               s_ip_hdr_ready,
    output logic                                             frame_open,
    output logic                                             m_ip_hdr_valid,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]                  m_ip_length,
    output logic [ip_mux_pkg::IP_TTL_W-1:0]                  m_ip_ttl,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0]                m_ip_protocol,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]                 m_ip_source_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]                 m_ip_dest_ip
);

    logic capture;

    // new frame starts when granted and the output slot frees up
    assign capture = !frame_open && grant_valid && (m_ip_hdr_ready || !m_ip_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open     <= 1'b0;
            s_ip_hdr_ready <= '0;
            m_ip_hdr_valid <= 1'b0;
        end else begin
            // one cycle pulse toward the granted source only
            s_ip_hdr_ready <= capture ? grant : '0;
            if (capture) begin
                frame_open     <= 1'b1;
                m_ip_hdr_valid <= 1'b1;
            end else begin
                if (frame_end) begin
                    frame_open <= 1'b0;
                end
                if (m_ip_hdr_ready) begin
                    m_ip_hdr_valid <= 1'b0;
                end
            end
        end
    end

    // header fields
    always_ff @(posedge clk) begin
        if (capture) begin
            m_ip_length    <= s_ip_length[grant_index];
            m_ip_ttl       <= s_ip_ttl[grant_index];
            m_ip_protocol  <= s_ip_protocol[grant_index];
            m_ip_source_ip <= s_ip_source_ip[grant_index];
            m_ip_dest_ip   <= s_ip_dest_ip[grant_index];
        end
    end

    // the arbiter still holds this source while its header ready is up
    a_hdr_ready_granted: assert property (
        @(posedge clk) disable iff (rst) (s_ip_hdr_ready & ~grant) == '0
    );

endmodule

`default_nettype wire

// File: design/ip_mux_arbiter.sv
// request arbiter for the IP frame mux
// grant is registered and held until the granted source acknowledges
// policy is round robin or fixed priority with index 0 highest

`timescale 1ns/10ps
`default_nettype none

module ip_mux_arbiter #(
    parameter int S_COUNT    = 4,
    parameter bit ARB_POLICY = ip_mux_pkg::ARB_ROUND_ROBIN
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [S_COUNT-1:0]         request,
    input  wire  [S_COUNT-1:0]         acknowledge,
    output logic [S_COUNT-1:0]         grant,
    output logic                       grant_valid,
    output logic [$clog2(S_COUNT)-1:0] grant_index
);

    import ip_mux_pkg::*;

    localparam int IDX_W = $clog2(S_COUNT);

    int unsigned        search_base;
    logic [S_COUNT-1:0] pick;
    logic [IDX_W-1:0]   pick_index;
    logic               pick_found;

    // first requester at or above the search base, wrapping
    always_comb begin
        pick       = '0;
        pick_index = '0;
        pick_found = 1'b0;
        if (ARB_POLICY == ARB_ROUND_ROBIN) begin
            // grant_index keeps the last winner after the grant drops
            search_base = (int'(grant_index) + 1) % S_COUNT;
        end else begin
            search_base = 0;
        end
        for (int i = 0; i < S_COUNT; i++) begin
            if (!pick_found && request[(search_base + i) % S_COUNT]) begin
                pick_found = 1'b1;
                pick_index = IDX_W'((search_base + i) % S_COUNT);
                pick[(search_base + i) % S_COUNT] = 1'b1;
            end
        end
    end

    // blocking grant, released on the acknowledge edge
    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            // so the first round robin search starts at source 0
            grant_index <= IDX_W'(S_COUNT - 1);
        end else if (grant_valid) begin
            if (|(acknowledge & grant)) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (pick_found) begin
            grant       <= pick;
            grant_valid <= 1'b1;
            grant_index <= pick_index;
        end
    end

    // at most one source holds the bus
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(grant)
    );

    // grant_valid tracks the grant vector
    a_grant_valid: assert property (
        @(posedge clk) disable iff (rst) grant_valid == (grant != '0)
    );

endmodule

`default_nettype wire

// File: design/ip_mux_pkg.sv
// shared definitions for the IP frame mux
// header field widths, payload width and arbitration policy codes

`default_nettype none

package ip_mux_pkg;

    // reduced IP header fields
    localparam int IP_LEN_W   = 16;
    localparam int IP_TTL_W   = 8;
    localparam int IP_PROTO_W = 8;
    localparam int IP_ADDR_W  = 32;

    // payload stream byte
    localparam int PAYLOAD_W = 8;

    // arbitration policy codes
    // fixed priority, index 0 wins
    localparam bit ARB_PRIORITY    = 1'b0;
    // rotating start after the last grant
    localparam bit ARB_ROUND_ROBIN = 1'b1;

endpackage

`default_nettype wire

// File: design/ip_payload_skid.sv
// payload output stage of the IP frame mux
// output register plus one temporary entry, so the upstream ready can
// be registered without losing a byte under back-pressure

`timescale 1ns/10ps
`default_nettype none

module ip_payload_skid (
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [ip_mux_pkg::PAYLOAD_W-1:0]   in_data,
    input  wire                                in_valid,
    input  wire                                in_last,
    output logic                               in_ready,
    output logic [ip_mux_pkg::PAYLOAD_W-1:0]   m_payload_tdata,
    output logic                               m_payload_tvalid,
    output logic                               m_payload_tlast,
    input  wire                                m_payload_tready
);

    import ip_mux_pkg::*;

    logic [PAYLOAD_W-1:0] temp_data;
    logic                 temp_last;
    logic                 temp_valid;

    logic in_ready_early;
    logic out_valid_next;
    logic temp_valid_next;
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle if the sink drains, or the temp entry cannot fill
    assign in_ready_early = m_payload_tready ||
                            (!temp_valid && (!m_payload_tvalid || !in_valid));

    always_comb begin
        out_valid_next    = m_payload_tvalid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;
        if (in_ready) begin
            if (m_payload_tready || !m_payload_tvalid) begin
                // output free, input goes straight there
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_tready) begin
            // drain the held byte
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_tvalid <= 1'b0;
            temp_valid       <= 1'b0;
            in_ready         <= 1'b0;
        end else begin
            m_payload_tvalid <= out_valid_next;
            temp_valid       <= temp_valid_next;
            in_ready         <= in_ready_early;
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_payload_tdata <= in_data;
            m_payload_tlast <= in_last;
        end else if (store_temp_to_out) begin
            m_payload_tdata <= temp_data;
            m_payload_tlast <= temp_last;
        end
        if (store_in_to_temp) begin
            temp_data <= in_data;
            temp_last <= in_last;
        end
    end

    // a byte is only accepted while the temp entry is empty
    a_no_overrun: assert property (
        @(posedge clk) disable iff (rst) (in_valid && in_ready) |-> !temp_valid
    );

endmodule

`default_nettype wire

// File: ip_arb_mux.f
+incdir+verif
design/ip_mux_pkg.sv
design/ip_mux_arbiter.sv
design/ip_hdr_select.sv
design/ip_payload_skid.sv
design/ip_arb_mux.sv
verif/tb_ip_arb_mux.sv

// File: verif/ip_mux_model.svh
// reference model for the IP frame mux testbench
// per-source queues of sent frames and the expected output byte order

// header word is {length, ttl, protocol, source ip, dest ip}
logic [95:0] model_hdr_q  [4][$];
logic [7:0]  model_byte_q [4][$];
// stream entries are {last, data}
logic [8:0]  expect_stream  [$];
logic [8:0]  receive_stream [$];

task automatic record_frame_header(input int src, input logic [95:0] hdr);
    model_hdr_q[src].push_back(hdr);
endtask

task automatic record_frame_byte(input int src, input logic [7:0] data);
    model_byte_q[src].push_back(data);
endtask

function automatic int frames_pending(input int src);
    return model_hdr_q[src].size();
endfunction

function automatic int frames_left();
    int total;
    total = 0;
    for (int i = 0; i < 4; i++) begin
        total += model_hdr_q[i].size();
    end
    return total;
endfunction

// oldest frame of a source, its bytes now expected at the output
task automatic release_frame(input int src, output logic [95:0] hdr);
    int         len;
    logic [7:0] data;
    logic       last;
    hdr = model_hdr_q[src].pop_front();
    len = int'(hdr[95:80]);
    for (int i = 0; i < len; i++) begin
        data = model_byte_q[src].pop_front();
        last = (i == len - 1);
        expect_stream.push_back({last, data});
    end
endtask

// File: verif/tb_ip_arb_mux.sv
// testbench for the arbitrated IP frame mux
// four random sources, a random back-pressure sink and a queue model

`timescale 1ns/10ps
`default_nettype none

module tb_ip_arb_mux;

    import ip_mux_pkg::*;

    localparam int FRAMES   = 6;
    localparam int TIMEOUT  = 20000;

    logic clk = 1'b0;
    logic rst;
    logic [3:0]                  s_ip_hdr_valid;
    logic [3:0]                  s_ip_hdr_ready;
    logic [3:0][IP_LEN_W-1:0]    s_ip_length;
    logic [3:0][IP_TTL_W-1:0]    s_ip_ttl;
    logic [3:0][IP_PROTO_W-1:0]  s_ip_protocol;
    logic [3:0][IP_ADDR_W-1:0]   s_ip_source_ip;
    logic [3:0][IP_ADDR_W-1:0]   s_ip_dest_ip;
    logic [3:0][PAYLOAD_W-1:0]   s_payload_tdata;
    logic [3:0]                  s_payload_tvalid;
    logic [3:0]                  s_payload_tlast;
    logic [3:0]                  s_payload_tready;
    logic                        m_ip_hdr_valid;
    logic                        m_ip_hdr_ready;
    logic [IP_LEN_W-1:0]         m_ip_length;
    logic [IP_TTL_W-1:0]         m_ip_ttl;
    logic [IP_PROTO_W-1:0]       m_ip_protocol;
    logic [IP_ADDR_W-1:0]        m_ip_source_ip;
    logic [IP_ADDR_W-1:0]        m_ip_dest_ip;
    logic [PAYLOAD_W-1:0]        m_payload_tdata;
    logic                        m_payload_tvalid;
    logic                        m_payload_tlast;
    logic                        m_payload_tready;

    integer      seed;
    int          errors;
    int          checks;
    int          last_src;
    logic [95:0] src_hdr  [4][FRAMES];
    logic [7:0]  src_data [4][FRAMES][8];
    int          fidx [4];
    int          bidx [4];
    bit          in_payload [4];
    bit          hdr_pend [4];
    bit          byte_pend [4];
    bit          hold_hdr;
    bit          hold_pay;
    logic [95:0] saved_hdr;
    logic [8:0]  saved_pay;

    `include "ip_mux_model.svh"

    ip_arb_mux #(
        .S_COUNT    (4),
        .ARB_POLICY (ARB_ROUND_ROBIN)
    ) i_ip_arb_mux (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle();
        checks++;
        assert (!m_ip_hdr_valid && !m_payload_tvalid && s_ip_hdr_ready == '0 &&
                s_payload_tready == '0) else begin
            $display("t=%0t outputs and ready signals are not idle around reset", $time);
            errors++;
        end
    endtask

    // random frames, with protocol naming the source and length the byte count
    task automatic make_frames();
        int len;
        for (int s = 0; s < 4; s++) begin
            for (int f = 0; f < FRAMES; f++) begin
                len = 1 + ($unsigned($random(seed)) % 8);
                src_hdr[s][f] = {16'(len), 8'($random(seed)), 8'(s),
                                 32'($random(seed)), 32'($random(seed))};
                record_frame_header(s, src_hdr[s][f]);
                for (int b = 0; b < len; b++) begin
                    src_data[s][f][b] = 8'($random(seed));
                    record_frame_byte(s, src_data[s][f][b]);
                end
            end
        end
    endtask

    // transfers seen last cycle move each source on, then new values go out
    task automatic drive_sources();
        int len;
        for (int s = 0; s < 4; s++) begin
            if (hdr_pend[s]) begin
                in_payload[s] = 1'b1;
                bidx[s] = 0;
            end else if (byte_pend[s]) begin
                len = int'(src_hdr[s][fidx[s]][95:80]);
                if (bidx[s] == len - 1) begin
                    fidx[s]++;
                    in_payload[s] = 1'b0;
                    s_payload_tvalid[s] = 1'b0;
                end else begin
                    bidx[s]++;
                end
            end
            s_ip_hdr_valid[s] = 1'b0;
            if (fidx[s] < FRAMES && !in_payload[s]) begin
                s_ip_hdr_valid[s] = 1'b1;
                {s_ip_length[s], s_ip_ttl[s], s_ip_protocol[s], s_ip_source_ip[s],
                 s_ip_dest_ip[s]} = src_hdr[s][fidx[s]];
            end else if (fidx[s] < FRAMES) begin
                // valid holds once raised
                if (!s_payload_tvalid[s] || byte_pend[s]) begin
                    s_payload_tvalid[s] = ($random(seed) & 3) != 0;
                end
                len = int'(src_hdr[s][fidx[s]][95:80]);
                s_payload_tdata[s] = src_data[s][fidx[s]][bidx[s]];
                s_payload_tlast[s] = (bidx[s] == len - 1);
            end
            hdr_pend[s]  = s_ip_hdr_valid[s] && s_ip_hdr_ready[s];
            byte_pend[s] = s_payload_tvalid[s] && s_payload_tready[s];
        end
    endtask

    task automatic take_header();
        logic [95:0] exp_hdr;
        int          src;
        bit          all_pending;
        src = int'(m_ip_protocol);
        checks++;
        assert (src < 4 && frames_pending(src) > 0) else begin
            $display("t=%0t header names source %0d, which has no frame queued", $time, src);
            errors++;
            return;
        end
        all_pending = 1'b1;
        for (int i = 0; i < 4; i++) begin
            if (frames_pending(i) == 0) begin
                all_pending = 1'b0;
            end
        end
        release_frame(src, exp_hdr);
        check_value("m_ip_length", 32'(m_ip_length), 32'(exp_hdr[95:80]));
        check_value("m_ip_ttl", 32'(m_ip_ttl), 32'(exp_hdr[79:72]));
        check_value("m_ip_protocol", 32'(m_ip_protocol), 32'(exp_hdr[71:64]));
        check_value("m_ip_source_ip", m_ip_source_ip, exp_hdr[63:32]);
        check_value("m_ip_dest_ip", m_ip_dest_ip, exp_hdr[31:0]);
        if (all_pending) begin
            check_value("round robin source", 32'(src), 32'((last_src + 1) % 4));
        end
        last_src = src;
    endtask

    task automatic watch_outputs();
        logic [8:0] got;
        logic [8:0] exp;
        m_ip_hdr_ready   = ($random(seed) & 3) != 0;
        m_payload_tready = ($random(seed) & 3) != 0;
        if (hold_hdr) begin
            // every header field stays put while stalled
            check_value("m_ip_hdr_valid", 32'(m_ip_hdr_valid), 32'd1);
            check_value("m_ip_length", 32'(m_ip_length), 32'(saved_hdr[95:80]));
            check_value("m_ip_ttl", 32'(m_ip_ttl), 32'(saved_hdr[79:72]));
            check_value("m_ip_protocol", 32'(m_ip_protocol), 32'(saved_hdr[71:64]));
            check_value("m_ip_source_ip", m_ip_source_ip, saved_hdr[63:32]);
            check_value("m_ip_dest_ip", m_ip_dest_ip, saved_hdr[31:0]);
        end
        if (hold_pay) begin
            check_value("m_payload_tvalid", 32'(m_payload_tvalid), 32'd1);
            check_value("held payload", 32'({m_payload_tlast, m_payload_tdata}), 32'(saved_pay));
        end
        if (m_ip_hdr_valid && m_ip_hdr_ready) begin
            take_header();
        end
        if (m_payload_tvalid && m_payload_tready) begin
            receive_stream.push_back({m_payload_tlast, m_payload_tdata});
        end
        hold_hdr  = m_ip_hdr_valid && !m_ip_hdr_ready;
        saved_hdr = {m_ip_length, m_ip_ttl, m_ip_protocol, m_ip_source_ip, m_ip_dest_ip};
        hold_pay  = m_payload_tvalid && !m_payload_tready;
        saved_pay = {m_payload_tlast, m_payload_tdata};
        while (expect_stream.size() > 0 && receive_stream.size() > 0) begin
            got = receive_stream.pop_front();
            exp = expect_stream.pop_front();
            check_value("m_payload_tdata", 32'(got[7:0]), 32'(exp[7:0]));
            check_value("m_payload_tlast", 32'(got[8]), 32'(exp[8]));
        end
    endtask

    function automatic bit all_done();
        bit done;
        done = frames_left() == 0 && expect_stream.size() == 0 &&
               receive_stream.size() == 0;
        for (int s = 0; s < 4; s++) begin
            if (fidx[s] < FRAMES) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    initial begin
        int cyc;
        seed = 32'h8c2a0daf;
        errors = 0;
        checks = 0;
        last_src = 3;
        hold_hdr = 1'b0;
        hold_pay = 1'b0;
        rst = 1'b1;
        s_ip_hdr_valid = '0;
        s_ip_length = '0;
        s_ip_ttl = '0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_payload_tdata = '0;
        s_payload_tvalid = '0;
        s_payload_tlast = '0;
        m_ip_hdr_ready = 1'b0;
        m_payload_tready = 1'b0;
        for (int s = 0; s < 4; s++) begin
            fidx[s] = 0;
            bidx[s] = 0;
            in_payload[s] = 1'b0;
            hdr_pend[s] = 1'b0;
            byte_pend[s] = 1'b0;
        end
        make_frames();
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle();
        cyc = 0;
        while (!all_done() && cyc < TIMEOUT) begin
            drive_sources();
            watch_outputs();
            @(negedge clk);
            cyc++;
        end
        if (!all_done()) begin
            $display("timeout after %0d cycles, %0d frames still queued in the model",
                     cyc, frames_left());
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
